// File: build.f
logic/mips_pkg.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_execute.sv
logic/mips_pc_unit.sv
logic/mips_core.sv
verif/mips_core_chk.sv
verif/mips_core_tb.sv

// File: Makefile
# Verilator build and run of the mips core testbench

VERILATOR       ?= verilator
TOP             ?= mips_core_tb
FILE_LIST       ?= build.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
SIM_FLAGS       ?= +verilator+error+limit+1000
PASS_MSG        ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/mips_core_tb.sv
// testbench for the single-cycle mips core with program assembler, reference model and store checks
`timescale 1ns/1ns

module mips_core_tb import mips_pkg::*; ();

   localparam word_t TEXT_START = 32'h00400000;

   logic       clk;
   logic       rst_b;
   word_addr_t inst_addr;
   word_t      inst;
   word_addr_t mem_addr;
   word_t      mem_data_in;
   logic [3:0] mem_write_en;
   word_t      mem_data_out;
   logic       halted;

   // instruction and data memory models
   word_t      imem [0:255];
   word_t      dmem [0:1023];
   word_addr_t iofs;

   // assembled image of both phases plus the model's registers and memory
   word_t      prog [$];
   word_t      mreg [0:31];
   word_t      mmem [0:1023];
   int         base_idx;
   int         len_a;
   int         halt_a;
   int         halt_b;

   // stores the model expects in order
   word_addr_t exp_addr [$];
   word_t      exp_data [$];

   // set once the model expects the core to sit halted
   bit         frozen;

   // stimulus table
   opcode_e    t_op [$];
   funct_e     t_fn [$];
   reg_idx_t   t_dst [$];
   word_t      t_a [$];
   word_t      t_b [$];
   bit         t_rnd [$];

   word_t      seed;
   int         errors;
   int         checks;

   mips_core #(
      .TEXT_START (TEXT_START)
   ) dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .halted       (halted)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // both ports read combinationally and anything outside the image reads as a reserved opcode
   assign iofs         = inst_addr - TEXT_START[31:2];
   assign inst         = (iofs < 30'd256) ? imem[iofs[7:0]] : {6'h3f, 26'h0};
   assign mem_data_out = dmem[mem_addr[9:0]];

   // byte lanes written at the edge
   always @(posedge clk)
   begin
      for (int k = 0; k < 4; k++)
      begin
         if (mem_write_en[k])
         begin
            dmem[mem_addr[9:0]][8*k +: 8] <= mem_data_in[8*k +: 8];
         end
      end
   end

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input word_addr_t got, input word_addr_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_strobe(input string name, input logic [3:0] got, input logic [3:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   function automatic word_t lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // pattern over the whole word address
   function automatic word_t fill_word(input logic [9:0] a);
      return {6'h15, a, 6'h2a, a};
   endfunction

   // result of one instruction by the mips rules
   function automatic word_t ref_result(input opcode_e op, input funct_e fn, input word_t a,
                                        input word_t b, input logic [4:0] sh,
                                        input logic [15:0] im);
      word_t se;
      word_t ze;
      word_t r;
      se = {{16{im[15]}}, im};
      ze = {16'h0000, im};
      r  = '0;
      case (op)
         OP_SPECIAL:
         begin
            case (fn)
               FN_ADDU: r = a + b;
               FN_SUBU: r = a - b;
               FN_AND:  r = a & b;
               FN_OR:   r = a | b;
               FN_XOR:  r = a ^ b;
               FN_NOR:  r = ~(a | b);
               FN_SLT:  r = {31'd0, $signed(a) < $signed(b)};
               FN_SLL:  r = b << sh;
               FN_SRL:  r = b >> sh;
               FN_SRA:  r = word_t'($signed(b) >>> sh);
               default: r = '0;
            endcase
         end
         OP_ADDIU: r = a + se;
         OP_SLTI:  r = {31'd0, $signed(a) < $signed(se)};
         OP_ANDI:  r = a & ze;
         OP_ORI:   r = a | ze;
         OP_XORI:  r = a ^ ze;
         OP_LUI:   r = {im, 16'h0000};
         default:  r = '0;
      endcase
      return r;
   endfunction

   task automatic emit(input word_t w);
      prog.push_back(w);
   endtask

   // emit one ALU instruction and update the model with its result
   task automatic alu_inst(input opcode_e op, input funct_e fn, input reg_idx_t dst,
                           input reg_idx_t rs, input reg_idx_t rt, input logic [4:0] sh,
                           input logic [15:0] im);
      if (op == OP_SPECIAL)
      begin
         emit({op, rs, rt, dst, sh, fn});
      end
      else
      begin
         emit({op, rs, dst, im});
      end
      if (dst != 5'd0)
      begin
         mreg[dst] = ref_result(op, fn, mreg[rs], mreg[rt], sh, im);
      end
   endtask

   task automatic load_const(input reg_idx_t idx, input word_t value);
      alu_inst(OP_LUI, FN_SLL, idx, 5'd0, 5'd0, 5'd0, value[31:16]);
      alu_inst(OP_ORI, FN_SLL, idx, idx, 5'd0, 5'd0, value[15:0]);
   endtask

   // sw off($zero) where a skipped store is emitted but never expected
   task automatic store(input reg_idx_t rt, input logic [15:0] off, input bit live);
      word_t ea;
      ea = {{16{off[15]}}, off};
      emit({OP_SW, 5'd0, rt, off});
      if (live)
      begin
         exp_addr.push_back(ea[31:2]);
         exp_data.push_back(mreg[rt]);
         mmem[ea[11:2]] = mreg[rt];
      end
   endtask

   task automatic load(input reg_idx_t rt, input logic [15:0] off);
      word_t ea;
      ea = {{16{off[15]}}, off};
      emit({OP_LW, 5'd0, rt, off});
      mreg[rt] = mmem[ea[11:2]];
   endtask

   // branch over one marker store while a second marker always runs
   task automatic branch_case(input opcode_e op, input reg_idx_t rs, input reg_idx_t rt,
                              input logic [15:0] off);
      bit taken;
      taken = (op == OP_BEQ) ? (mreg[rs] == mreg[rt]) : (mreg[rs] != mreg[rt]);
      emit({op, rs, rt, 16'h0001});
      store(rs, off, !taken);
      store(rs, off + 16'h0004, 1'b1);
   endtask

   task automatic jump_case(input logic [15:0] off);
      word_t dest;
      dest = TEXT_START + 32'(4 * (prog.size() - base_idx)) + 32'd8;
      emit({OP_J, dest[27:2]});
      store(5'd8, off, 1'b0);
      store(5'd8, off + 16'h0004, 1'b1);
   endtask

   task automatic add_row(input opcode_e op, input funct_e fn, input reg_idx_t dst,
                          input word_t a, input word_t b, input bit rnd);
      t_op.push_back(op);
      t_fn.push_back(fn);
      t_dst.push_back(dst);
      t_a.push_back(a);
      t_b.push_back(b);
      t_rnd.push_back(rnd);
   endtask

   task automatic build_table();
      add_row(OP_SPECIAL, FN_ADDU, 5'd3, 32'h7fffffff, 32'h00000001, 1'b0);
      add_row(OP_SPECIAL, FN_SUBU, 5'd3, 32'h80000000, 32'h00000001, 1'b0);
      add_row(OP_SPECIAL, FN_AND,  5'd3, 32'hf0f0f0f0, 32'hff00ff00, 1'b0);
      add_row(OP_SPECIAL, FN_OR,   5'd3, 32'hf0f0f0f0, 32'h0f0f0001, 1'b0);
      add_row(OP_SPECIAL, FN_XOR,  5'd3, 32'hffff0000, 32'h0ff00ff0, 1'b0);
      add_row(OP_SPECIAL, FN_NOR,  5'd3, 32'h12345678, 32'h00ff0000, 1'b0);
      add_row(OP_SPECIAL, FN_SLT,  5'd3, 32'hffffffff, 32'h00000001, 1'b0);
      add_row(OP_SPECIAL, FN_SLT,  5'd3, 32'h00000001, 32'h80000000, 1'b0);
      add_row(OP_SPECIAL, FN_SLL,  5'd3, 32'h80000001, 32'h0000001f, 1'b0);
      add_row(OP_SPECIAL, FN_SRL,  5'd3, 32'h80000000, 32'h00000004, 1'b0);
      add_row(OP_SPECIAL, FN_SRA,  5'd3, 32'h80000000, 32'h00000004, 1'b0);
      add_row(OP_ADDIU,   FN_SLL,  5'd3, 32'h00000001, 32'h0000ffff, 1'b0);
      add_row(OP_SLTI,    FN_SLL,  5'd3, 32'hfffffffe, 32'h0000ffff, 1'b0);
      add_row(OP_ANDI,    FN_SLL,  5'd3, 32'hffffffff, 32'h00008001, 1'b0);
      add_row(OP_ORI,     FN_SLL,  5'd3, 32'h00000000, 32'h00008000, 1'b0);
      add_row(OP_XORI,    FN_SLL,  5'd3, 32'hffffffff, 32'h0000ffff, 1'b0);
      add_row(OP_LUI,     FN_SLL,  5'd3, 32'h00000000, 32'h00008765, 1'b0);
      // destination $zero must keep reading zero
      add_row(OP_ADDIU,   FN_SLL,  5'd0, 32'h00000055, 32'h00000005, 1'b0);
      add_row(OP_SPECIAL, FN_ADDU, 5'd3, 32'h00000000, 32'h00000000, 1'b1);
      add_row(OP_SPECIAL, FN_SUBU, 5'd3, 32'h00000000, 32'h00000000, 1'b1);
      add_row(OP_SPECIAL, FN_SLT,  5'd3, 32'h00000000, 32'h00000000, 1'b1);
      add_row(OP_SPECIAL, FN_SRA,  5'd3, 32'h00000000, 32'h00000000, 1'b1);
      add_row(OP_SLTI,    FN_SLL,  5'd3, 32'h00000000, 32'h00000000, 1'b1);
      add_row(OP_XORI,    FN_SLL,  5'd3, 32'h00000000, 32'h00000000, 1'b1);
   endtask

   // phase one covers the table, load/store, control flow and syscalls
   task automatic assemble_first();
      word_t a;
      word_t b;
      base_idx = 0;
      for (int i = 0; i < t_op.size(); i++)
      begin
         a = t_rnd[i] ? lcg_next() : t_a[i];
         b = t_rnd[i] ? lcg_next() : t_b[i];
         load_const(5'd1, a);
         load_const(5'd2, b);
         if (t_op[i] != OP_SPECIAL)
         begin
            alu_inst(t_op[i], t_fn[i], t_dst[i], 5'd1, 5'd0, 5'd0, b[15:0]);
         end
         else if (t_fn[i] == FN_SLL || t_fn[i] == FN_SRL || t_fn[i] == FN_SRA)
         begin
            alu_inst(t_op[i], t_fn[i], t_dst[i], 5'd0, 5'd1, b[4:0], 16'h0000);
         end
         else
         begin
            alu_inst(t_op[i], t_fn[i], t_dst[i], 5'd1, 5'd2, 5'd0, 16'h0000);
         end
         store(t_dst[i], 16'h0400 + 16'(4 * i), 1'b1);
      end
      // store a word, reload it into another register and read one never written
      load_const(5'd5, 32'hcafef00d);
      store(5'd5, 16'h0800, 1'b1);
      load(5'd6, 16'h0800);
      store(5'd6, 16'h0804, 1'b1);
      load(5'd7, 16'h0a00);
      store(5'd7, 16'h0808, 1'b1);
      alu_inst(OP_ADDIU, FN_SLL, 5'd8, 5'd0, 5'd0, 5'd0, 16'd7);
      alu_inst(OP_ADDIU, FN_SLL, 5'd9, 5'd0, 5'd0, 5'd0, 16'd7);
      alu_inst(OP_ADDIU, FN_SLL, 5'd10, 5'd0, 5'd0, 5'd0, 16'd9);
      branch_case(OP_BEQ, 5'd8, 5'd9, 16'h0810);
      branch_case(OP_BEQ, 5'd8, 5'd10, 16'h0818);
      branch_case(OP_BNE, 5'd8, 5'd10, 16'h0820);
      branch_case(OP_BNE, 5'd8, 5'd9, 16'h0828);
      jump_case(16'h0830);
      // $v0 = 4 lets the core run on while $v0 = 10 stops it
      alu_inst(OP_ADDIU, FN_SLL, REG_V0, 5'd0, 5'd0, 5'd0, 16'd4);
      emit({OP_SPECIAL, 20'h00000, FN_SYSCALL});
      store(5'd8, 16'h0840, 1'b1);
      alu_inst(OP_ADDIU, FN_SLL, REG_V0, 5'd0, 5'd0, 5'd0, 16'd10);
      halt_a = prog.size();
      emit({OP_SPECIAL, 20'h00000, FN_SYSCALL});
      store(5'd8, 16'h0844, 1'b0);
   endtask

   // phase two after a fresh reset checks zeroed registers and the reserved-opcode halt
   task automatic assemble_second();
      base_idx = prog.size();
      for (int i = 0; i < 32; i++)
      begin
         mreg[i] = '0;
      end
      store(5'd3, 16'h0908, 1'b1);
      load_const(5'd1, 32'h5a5a1234);
      store(5'd1, 16'h0900, 1'b1);
      halt_b = prog.size() - base_idx;
      emit({6'h3f, 26'h0});
      store(5'd1, 16'h0904, 1'b0);
   endtask

   task automatic load_image(input int from, input int upto);
      for (int i = 0; i < 256; i++)
      begin
         imem[i] = {6'h3f, 18'h0, 8'(i)};
      end
      for (int k = from; k < upto; k++)
      begin
         imem[k - from] = prog[k];
      end
   endtask

   // waits for the halting instruction and then watches the frozen state
   task automatic check_halt(input int idx);
      word_addr_t hw;
      hw = TEXT_START[31:2] + 30'(idx);
      while (inst_addr !== hw)
      begin
         check_bit("halted", halted, 1'b0);
         @(negedge clk);
      end
      check_bit("halted", halted, 1'b0);
      // a sw placed under the frozen pc must neither store nor move the pc
      @(posedge clk);
      #10;
      frozen    = 1'b1;
      imem[idx] = {OP_SW, 5'd0, 5'd8, 16'h0848};
      @(negedge clk);
      repeat (4)
      begin
         check_bit("halted", halted, 1'b1);
         check_addr("inst_addr", inst_addr, hw);
         @(negedge clk);
      end
   endtask

   task automatic release_reset();
      frozen = 1'b0;
      repeat (16) @(posedge clk);
      #10 rst_b = 1'b1;
      @(negedge clk);
      check_addr("inst_addr", inst_addr, TEXT_START[31:2]);
      check_bit("halted", halted, 1'b0);
   endtask

   // store monitor sampling mid-cycle where the strobe is set only on a sw that runs
   always @(negedge clk)
   begin
      if (rst_b)
      begin
         if (inst[31:26] == OP_SW && !frozen)
         begin
            check_strobe("mem_write_en", mem_write_en, 4'hf);
         end
         else
         begin
            check_strobe("mem_write_en", mem_write_en, 4'h0);
         end
         if (mem_write_en != 4'h0)
         begin
            if (exp_addr.size() == 0)
            begin
               errors++;
               $display("store to %h at %0t ns where none was expected", mem_addr, $time);
            end
            else
            begin
               check_addr("mem_addr", mem_addr, exp_addr.pop_front());
               check_word("mem_data_in", mem_data_in, exp_data.pop_front());
            end
         end
      end
   end

   // watchdog sized from both program images
   initial
   begin
      #1;
      #((prog.size() + 64) * 100);
      $display("timeout: the core never reached the expected halt");
      $display("Something failed");
      $finish;
   end

   initial
   begin
      rst_b  = 1'b0;
      frozen = 1'b0;
      errors = 0;
      checks = 0;
      seed   = 32'hab86;
      for (int i = 0; i < 1024; i++)
      begin
         dmem[i] = fill_word(10'(i));
         mmem[i] = fill_word(10'(i));
      end
      for (int i = 0; i < 32; i++)
      begin
         mreg[i] = '0;
      end
      build_table();
      assemble_first();
      len_a = prog.size();
      assemble_second();
      load_image(0, len_a);
      release_reset();
      check_halt(halt_a);
      // second reset with the reserved-opcode program
      @(posedge clk);
      #10 rst_b = 1'b0;
      load_image(len_a, prog.size());
      release_reset();
      check_halt(halt_b);
      if (exp_addr.size() != 0)
      begin
         errors++;
         $display("%0d expected stores never appeared", exp_addr.size());
      end
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               dut.u_chk.fails);
      if (errors == 0 && dut.u_chk.fails == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: verif/mips_core_chk.sv
// assertion checker for mips core reset state, halt behavior and store strobe
`timescale 1ns/1ns

module mips_core_chk import mips_pkg::*; #(
   parameter word_t TEXT_START = 32'h00400000
) (
   input logic       clk,
   input logic       rst_b,
   input word_addr_t inst_addr,
   input logic [3:0] mem_write_en,
   input logic       halted
);

   // failing assertions, read back by the testbench
   int unsigned fails = 0;

   // first edge after reset release sees the text base and no halt
   reset_state: assert property (@(posedge clk)
      $rose(rst_b) |-> (inst_addr == TEXT_START[31:2]) && !halted)
      else
      begin
         fails++;
         $error("core left reset with a wrong pc or halted set");
      end

   // halted only clears through reset
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else
      begin
         fails++;
         $error("halted dropped without a reset");
      end

   pc_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else
      begin
         fails++;
         $error("instruction address moved while halted");
      end

   // no strobe while halted, and only whole words otherwise
   no_store_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (mem_write_en == 4'h0))
      else
      begin
         fails++;
         $error("store strobe active while halted");
      end

   strobe_shape: assert property (@(posedge clk) disable iff (!rst_b)
      (mem_write_en == 4'h0) || (mem_write_en == 4'hf))
      else
      begin
         fails++;
         $error("store strobe is neither empty nor a full word");
      end

endmodule

bind mips_core mips_core_chk #(
   .TEXT_START (TEXT_START)
) u_chk (
   .clk          (clk),
   .rst_b        (rst_b),
   .inst_addr    (inst_addr),
   .mem_write_en (mem_write_en),
   .halted       (halted)
);

// File: logic/mips_core.sv
// single-cycle mips core top level joining decode, register file, execute and PC
`timescale 1ns/1ns

module mips_core import mips_pkg::*; #(
   parameter word_t TEXT_START = 32'h00400000
) (
   input  logic       clk,
   input  logic       rst_b,
   output word_addr_t inst_addr,
   input  word_t      inst,
   output word_addr_t mem_addr,
   output word_t      mem_data_in,
   output logic [3:0] mem_write_en,
   input  word_t      mem_data_out,
   output logic       halted
);

   // decode outputs
   reg_idx_t    rs_idx;
   reg_idx_t    rt_idx;
   reg_idx_t    wr_idx;
   logic        wr_en;
   alu_op_e     alu_op;
   logic        use_imm;
   word_t       imm;
   logic [4:0]  shamt;
   logic [3:0]  dcd_write_en;
   logic        load;
   pc_sel_e     pc_sel;
   logic [25:0] target;
   logic        syscall;
   logic        reserved;

   // datapath
   word_t rs_data;
   word_t rt_data;
   word_t alu_result;
   word_t wr_data;

   mips_decode u_decode (
      .inst         (inst),
      .rs_idx       (rs_idx),
      .rt_idx       (rt_idx),
      .wr_idx       (wr_idx),
      .wr_en        (wr_en),
      .alu_op       (alu_op),
      .use_imm      (use_imm),
      .imm          (imm),
      .shamt        (shamt),
      .mem_write_en (dcd_write_en),
      .load         (load),
      .pc_sel       (pc_sel),
      .target       (target),
      .syscall      (syscall),
      .reserved     (reserved)
   );

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs_idx),
      .rt_idx  (rt_idx),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wr_idx  (wr_idx),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .halted  (halted)
   );

   mips_execute u_execute (
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .imm          (imm),
      .use_imm      (use_imm),
      .shamt        (shamt),
      .alu_op       (alu_op),
      .load         (load),
      .mem_data_out (mem_data_out),
      .alu_result   (alu_result),
      .wr_data      (wr_data)
   );

   mips_pc_unit #(
      .TEXT_START (TEXT_START)
   ) u_pc_unit (
      .clk       (clk),
      .rst_b     (rst_b),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .imm       (imm),
      .target    (target),
      .pc_sel    (pc_sel),
      .syscall   (syscall),
      .reserved  (reserved),
      .inst_addr (inst_addr),
      .halted    (halted)
   );

   // word-aligned data port, store data straight from rt
   assign mem_addr    = alu_result[31:2];
   assign mem_data_in = rt_data;
   // no stores once halted
   assign mem_write_en = dcd_write_en & {4{~halted}};

endmodule

// File: logic/mips_pc_unit.sv
// mips program counter with branch and jump targets and halt detection
`timescale 1ns/1ns

module mips_pc_unit import mips_pkg::*; #(
   parameter word_t TEXT_START = 32'h00400000
) (
   input  logic        clk,
   input  logic        rst_b,
   input  word_t       rs_data,
   input  word_t       rt_data,
   input  word_t       imm,
   input  logic [25:0] target,
   input  pc_sel_e     pc_sel,
   input  logic        syscall,
   input  logic        reserved,
   output word_addr_t  inst_addr,
   output logic        halted
);

   word_t pc;
   word_t pc_plus4;
   word_t branch_target;
   word_t jump_target;
   word_t next_pc;
   logic  halt_now;

   assign pc_plus4      = pc + 32'd4;
   // word offset relative to the delay-free pc+4
   assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
   assign jump_target   = {pc[31:28], target, 2'b00};

   always_comb
   begin
      case (pc_sel)
         PC_BRANCH_EQ: next_pc = (rs_data == rt_data) ? branch_target : pc_plus4;
         PC_BRANCH_NE: next_pc = (rs_data != rt_data) ? branch_target : pc_plus4;
         PC_JUMP:      next_pc = jump_target;
         default:      next_pc = pc_plus4;
      endcase
   end

   // rs_data carries $v0 during syscall
   assign halt_now = reserved | (syscall & (rs_data == SYSCALL_EXIT));

   assign inst_addr = pc[31:2];

   // pc stays on the halting instruction
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc <= TEXT_START;
      end
      else if (!halted && !halt_now)
      begin
         pc <= next_pc;
      end
   end

   // sticky until the next reset
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         halted <= 1'b0;
      end
      else if (halt_now)
      begin
         halted <= 1'b1;
      end
   end

endmodule

// File: logic/mips_execute.sv
// mips execute stage: operand select, ALU and write-back select
`timescale 1ns/1ns

module mips_execute import mips_pkg::*; (
   input  word_t      rs_data,
   input  word_t      rt_data,
   input  word_t      imm,
   input  logic       use_imm,
   input  logic [4:0] shamt,
   input  alu_op_e    alu_op,
   input  logic       load,
   input  word_t      mem_data_out,
   output word_t      alu_result,
   output word_t      wr_data
);

   // second operand, rt for R-type and the extended immediate otherwise
   word_t op_b;

   assign op_b = use_imm ? imm : rt_data;

   always_comb
   begin
      case (alu_op)
         ALU_ADD: alu_result = rs_data + op_b;
         ALU_SUB: alu_result = rs_data - op_b;
         // shifts take rt by the fixed shamt field
         ALU_SLL: alu_result = rt_data << shamt;
         ALU_SRL: alu_result = rt_data >> shamt;
         ALU_SRA: alu_result = word_t'($signed(rt_data) >>> shamt);
         ALU_AND: alu_result = rs_data & op_b;
         ALU_OR:  alu_result = rs_data | op_b;
         ALU_XOR: alu_result = rs_data ^ op_b;
         ALU_NOR: alu_result = ~(rs_data | op_b);
         // signed compare for slt and slti
         ALU_SLT:
         begin
            if ($signed(rs_data) < $signed(op_b))
            begin
               alu_result = 32'd1;
            end
            else
            begin
               alu_result = 32'd0;
            end
         end
         // immediate into the upper half, lower half cleared
         ALU_LUI: alu_result = {imm[15:0], 16'h0000};
         default: alu_result = '0;
      endcase
   end

   // load data replaces the address on lw
   assign wr_data = load ? mem_data_out : alu_result;

endmodule

// File: logic/mips_regfile.sv
// mips register file, 32 entries with $zero hardwired, two reads and one write
`timescale 1ns/1ns

module mips_regfile import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs_idx,
   input  reg_idx_t rt_idx,
   output word_t    rs_data,
   output word_t    rt_data,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data,
   input  logic     wr_en,
   input  logic     halted
);

   // only $1..$31 have storage
   word_t regs [1:31];

   // $zero always reads as zero
   assign rs_data = (rs_idx == 5'd0) ? '0 : regs[rs_idx];
   assign rt_data = (rt_idx == 5'd0) ? '0 : regs[rt_idx];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < 32; i++)
         begin
            regs[i] <= '0;
         end
      end
      // frozen once the core halts
      else if (wr_en && (wr_idx != 5'd0) && !halted)
      begin
         regs[wr_idx] <= wr_data;
      end
   end

endmodule

// File: logic/mips_decode.sv
// mips instruction decoder producing fields, extended immediate and control levels
`timescale 1ns/1ns

module mips_decode import mips_pkg::*; (
   input  word_t       inst,
   output reg_idx_t    rs_idx,
   output reg_idx_t    rt_idx,
   output reg_idx_t    wr_idx,
   output logic        wr_en,
   output alu_op_e     alu_op,
   output logic        use_imm,
   output word_t       imm,
   output logic [4:0]  shamt,
   output logic [3:0]  mem_write_en,
   output logic        load,
   output pc_sel_e     pc_sel,
   output logic [25:0] target,
   output logic        syscall,
   output logic        reserved
);

   opcode_e op;
   funct_e  funct;
   // destination is rd for R-type, rt otherwise
   logic    dst_rd;
   // sign- or zero-extend the 16-bit immediate
   logic    sign_ext;

   assign op     = opcode_e'(inst[31:26]);
   assign funct  = funct_e'(inst[5:0]);
   assign rt_idx = inst[20:16];
   assign shamt  = inst[10:6];
   assign target = inst[25:0];

   // syscall reads $v0 through the rs port so the PC unit can test it
   assign rs_idx = syscall ? REG_V0 : inst[25:21];
   assign wr_idx = dst_rd ? inst[15:11] : inst[20:16];
   assign imm    = sign_ext ? {{16{inst[15]}}, inst[15:0]} : {16'h0000, inst[15:0]};

   always_comb
   begin
      // defaults describe a no-op that writes nothing
      wr_en        = 1'b0;
      alu_op       = ALU_ADD;
      use_imm      = 1'b0;
      mem_write_en = 4'b0000;
      load         = 1'b0;
      pc_sel       = PC_SEQ;
      syscall      = 1'b0;
      reserved     = 1'b0;
      dst_rd       = 1'b0;
      sign_ext     = 1'b1;
      case (op)
         OP_SPECIAL:
         begin
            dst_rd = 1'b1;
            wr_en  = 1'b1;
            case (funct)
               FN_SLL:     alu_op = ALU_SLL;
               FN_SRL:     alu_op = ALU_SRL;
               FN_SRA:     alu_op = ALU_SRA;
               FN_ADDU:    alu_op = ALU_ADD;
               FN_SUBU:    alu_op = ALU_SUB;
               FN_AND:     alu_op = ALU_AND;
               FN_OR:      alu_op = ALU_OR;
               FN_XOR:     alu_op = ALU_XOR;
               FN_NOR:     alu_op = ALU_NOR;
               FN_SLT:     alu_op = ALU_SLT;
               FN_SYSCALL:
               begin
                  wr_en   = 1'b0;
                  syscall = 1'b1;
               end
               default:
               begin
                  wr_en    = 1'b0;
                  reserved = 1'b1;
               end
            endcase
         end
         // branches compare rs and rt in the PC unit, offset stays sign-extended
         OP_BEQ:   pc_sel = PC_BRANCH_EQ;
         OP_BNE:   pc_sel = PC_BRANCH_NE;
         OP_J:     pc_sel = PC_JUMP;
         OP_ADDIU:
         begin
            wr_en   = 1'b1;
            use_imm = 1'b1;
         end
         OP_SLTI:
         begin
            wr_en   = 1'b1;
            use_imm = 1'b1;
            alu_op  = ALU_SLT;
         end
         OP_ANDI:
         begin
            wr_en    = 1'b1;
            use_imm  = 1'b1;
            sign_ext = 1'b0;
            alu_op   = ALU_AND;
         end
         OP_ORI:
         begin
            wr_en    = 1'b1;
            use_imm  = 1'b1;
            sign_ext = 1'b0;
            alu_op   = ALU_OR;
         end
         OP_XORI:
         begin
            wr_en    = 1'b1;
            use_imm  = 1'b1;
            sign_ext = 1'b0;
            alu_op   = ALU_XOR;
         end
         OP_LUI:
         begin
            wr_en    = 1'b1;
            sign_ext = 1'b0;
            alu_op   = ALU_LUI;
         end
         // address is rs plus the sign-extended offset
         OP_LW:
         begin
            wr_en   = 1'b1;
            use_imm = 1'b1;
            load    = 1'b1;
         end
         OP_SW:
         begin
            use_imm      = 1'b1;
            mem_write_en = 4'b1111;
         end
         default:  reserved = 1'b1;
      endcase
   end

endmodule

// File: logic/mips_pkg.sv
// mips core shared types, opcode and funct encodings, ALU and next-PC selects
package mips_pkg;

   // data word and the 30-bit word address seen on the memory ports
   typedef logic [31:0] word_t;
   typedef logic [29:0] word_addr_t;
   typedef logic [4:0]  reg_idx_t;

   // primary opcode, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_e;

   // secondary opcode under special, inst[5:0]
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   // operation performed by the execute block
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_LUI
   } alu_op_e;

   // source of the next PC
   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BRANCH_EQ,
      PC_BRANCH_NE,
      PC_JUMP
   } pc_sel_e;

   // syscall halts only when $v0 holds the exit code
   localparam word_t    SYSCALL_EXIT = 32'd10;
   localparam reg_idx_t REG_V0       = 5'd2;

endpackage
